// ==== design/eeprom_pkg.sv ====
package eeprom_pkg;

    // a control byte must carry this code in its upper four bits.
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    localparam int BYTE_WIDTH = 8;

    // the byte address is three block bits followed by the word address.
    localparam int ADDR_WIDTH  = 11;
    localparam int BLOCK_WIDTH = ADDR_WIDTH - BYTE_WIDTH;
    localparam int MEM_DEPTH   = 2048;

    // depth of the scl and data synchronizers.
    localparam int SYNC_STAGES = 2;

    // ack states drive the acknowledge in the ninth slot of a byte.
    // ignore waits for the next start without touching the bus.
    typedef enum logic [3:0] {
        idle,
        control,
        control_ack,
        word_addr,
        addr_ack,
        write_data,
        write_ack,
        read_data,
        master_ack,
        ignore
    } eeprom_state_t;

endpackage

// ==== design/i2c_line_monitor.sv ====
`timescale 1ns/1ps

module i2c_line_monitor
    import eeprom_pkg::*;
(
    input  logic sda,
    input  logic rst_n,
    input  logic scl,
    input  logic data,
    output logic bit_in,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_seen,
    output logic stop_seen
);

    logic [SYNC_STAGES-1:0] scl_sync;
    logic [SYNC_STAGES-1:0] data_sync;
    logic                   scl_now;
    logic                   data_now;
    logic                   scl_prev;
    logic                   data_prev;

    assign scl_now  = scl_sync[SYNC_STAGES-1];
    assign data_now = data_sync[SYNC_STAGES-1];

    // data_prev is aligned with the edge pulses below.
    assign bit_in = data_prev;

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            // an idle bus has both lines high.
            scl_sync   <= '1;
            data_sync  <= '1;
            scl_prev   <= 1'b1;
            data_prev  <= 1'b1;
            scl_rise   <= 1'b0;
            scl_fall   <= 1'b0;
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
        end
        else
        begin
            scl_sync   <= {scl_sync[SYNC_STAGES-2:0], scl};
            data_sync  <= {data_sync[SYNC_STAGES-2:0], data};
            scl_prev   <= scl_now;
            data_prev  <= data_now;
            scl_rise   <= scl_now && !scl_prev;
            scl_fall   <= !scl_now && scl_prev;
            // data may only move while scl is low, except for start and stop.
            start_seen <= scl_now && scl_prev && data_prev && !data_now;
            stop_seen  <= scl_now && scl_prev && !data_prev && data_now;
        end
    end

endmodule

// ==== design/i2c_bit_counter.sv ====
`timescale 1ns/1ps

module i2c_bit_counter (
    input  logic       sda,
    input  logic       rst_n,
    input  logic       scl_rise,
    input  logic       scl_fall,
    input  logic       frame_clear,
    output logic [3:0] bit_index,
    output logic       byte_done,
    output logic       ack_slot
);

    always_ff @(posedge sda)
    begin
        if (!rst_n || frame_clear)
        begin
            bit_index <= 4'd0;
            byte_done <= 1'b0;
            ack_slot  <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            // the ninth rise is the acknowledge bit and leaves the count at 8.
            if (scl_rise && bit_index < 4'd8)
            begin
                bit_index <= bit_index + 4'd1;
                byte_done <= (bit_index == 4'd7);
            end
            if (scl_fall)
            begin
                if (ack_slot)
                begin
                    ack_slot  <= 1'b0;
                    bit_index <= 4'd0;
                end
                else if (bit_index == 4'd8)
                begin
                    ack_slot <= 1'b1;
                end
            end
        end
    end

    assert property (@(posedge sda) disable iff (!rst_n)
        bit_index <= 4'd8 && (!ack_slot || bit_index == 4'd8));

endmodule

// ==== design/eeprom_shifter.sv ====
`timescale 1ns/1ps

module eeprom_shifter
    import eeprom_pkg::*;
(
    input  logic                  sda,
    input  logic                  rst_n,
    input  logic                  bit_in,
    input  logic                  scl_rise,
    input  logic                  scl_fall,
    input  logic                  shift_en,
    input  logic                  load_en,
    input  logic [BYTE_WIDTH-1:0] load_byte,
    output logic [BYTE_WIDTH-1:0] rx_byte,
    output logic                  tx_bit
);

    logic [BYTE_WIDTH-1:0] tx_reg;

    // receive side, msb first, sampled while scl is high.
    always_ff @(posedge sda)
    begin
        if (shift_en && scl_rise)
        begin
            rx_byte <= {rx_byte[BYTE_WIDTH-2:0], bit_in};
        end
    end

    // transmit side. A load lands on the fall that opens the first bit, so it
    // takes priority over the shift.
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            tx_reg <= '1;
        end
        else if (load_en)
        begin
            tx_reg <= load_byte;
        end
        else if (scl_fall && !shift_en)
        begin
            tx_reg <= {tx_reg[BYTE_WIDTH-2:0], 1'b1};
        end
    end

    assign tx_bit = tx_reg[BYTE_WIDTH-1];

endmodule

// ==== design/eeprom_array.sv ====
`timescale 1ns/1ps

module eeprom_array
    import eeprom_pkg::*;
(
    input  logic                  sda,
    input  logic                  mem_we,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  logic [BYTE_WIDTH-1:0] wr_byte,
    output logic [BYTE_WIDTH-1:0] rd_byte
);

    logic [BYTE_WIDTH-1:0] mem [MEM_DEPTH];

    // the read port follows mem_addr one cycle later. A write in the same
    // cycle returns the old byte.
    always_ff @(posedge sda)
    begin
        if (mem_we)
        begin
            mem[mem_addr] <= wr_byte;
        end
        rd_byte <= mem[mem_addr];
    end

    assert property (@(posedge sda) mem_we |-> !$isunknown(mem_addr));

endmodule

// ==== design/i2c_eeprom_ctrl.sv ====
`timescale 1ns/1ps

module i2c_eeprom_ctrl
    import eeprom_pkg::*;
(
    input  logic                  sda,
    input  logic                  rst_n,
    input  logic                  bit_in,
    input  logic                  scl_fall,
    input  logic                  start_seen,
    input  logic                  stop_seen,
    input  logic                  byte_done,
    input  logic                  ack_slot,
    input  logic [BYTE_WIDTH-1:0] rx_byte,
    input  logic                  tx_bit,
    output logic                  frame_clear,
    output logic                  shift_en,
    output logic                  load_en,
    output logic                  mem_we,
    output logic                  data_low,
    output logic [ADDR_WIDTH-1:0] mem_addr
);

    eeprom_state_t          state;
    logic [ADDR_WIDTH-1:0]  ptr;
    logic [BLOCK_WIDTH-1:0] blk_bits;
    logic                   read_mode;
    logic                   master_nack;
    logic                   ack_end;
    logic                   slave_ack;
    logic                   code_ok;

    assign ack_end     = scl_fall && ack_slot;
    assign frame_clear = start_seen || stop_seen;
    assign mem_addr    = ptr;
    assign code_ok     = (rx_byte[BYTE_WIDTH-1 -: 4] == DEVICE_CODE);

    assign shift_en  = (state == control) || (state == word_addr) || (state == write_data);
    assign slave_ack = (state == control_ack) || (state == addr_ack) || (state == write_ack);

    // the next read byte goes into the transmitter as the ack slot closes.
    assign load_en = ack_end &&
                     ((state == control_ack && read_mode) ||
                      (state == master_ack && !master_nack));

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state       <= idle;
            ptr         <= '0;
            blk_bits    <= '0;
            read_mode   <= 1'b0;
            master_nack <= 1'b1;
            mem_we      <= 1'b0;
        end
        else
        begin
            mem_we <= (state == write_data) && byte_done;
            if (mem_we)
            begin
                ptr <= ptr + 1'b1;
            end
            // the last value taken before the closing fall was sampled with scl high.
            if (ack_slot && !scl_fall)
            begin
                master_nack <= bit_in;
            end

            if (start_seen)
            begin
                state <= control;
            end
            else if (stop_seen)
            begin
                state <= idle;
            end
            else
            begin
                case (state)
                    control:
                    begin
                        if (byte_done)
                        begin
                            if (!code_ok)
                            begin
                                state <= ignore;
                            end
                            else
                            begin
                                state     <= control_ack;
                                read_mode <= rx_byte[0];
                                if (rx_byte[0])
                                begin
                                    ptr[ADDR_WIDTH-1:BYTE_WIDTH] <= rx_byte[BLOCK_WIDTH:1];
                                end
                                else
                                begin
                                    blk_bits <= rx_byte[BLOCK_WIDTH:1];
                                end
                            end
                        end
                    end
                    control_ack:
                    begin
                        if (ack_end)
                        begin
                            state <= read_mode ? read_data : word_addr;
                        end
                    end
                    word_addr:
                    begin
                        if (byte_done)
                        begin
                            ptr   <= {blk_bits, rx_byte};
                            state <= addr_ack;
                        end
                    end
                    addr_ack, write_ack:
                    begin
                        if (ack_end)
                        begin
                            state <= write_data;
                        end
                    end
                    write_data:
                    begin
                        if (byte_done)
                        begin
                            state <= write_ack;
                        end
                    end
                    read_data:
                    begin
                        if (byte_done)
                        begin
                            ptr   <= ptr + 1'b1;
                            state <= master_ack;
                        end
                    end
                    master_ack:
                    begin
                        if (ack_end)
                        begin
                            state <= master_nack ? ignore : read_data;
                        end
                    end
                    idle, ignore:
                    begin
                        state <= state;
                    end
                    default:
                    begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

    // in master_ack the last data bit is held until scl falls, since a release
    // while scl is high would look like a stop.
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            data_low <= 1'b0;
        end
        else if (slave_ack)
        begin
            data_low <= ack_slot;
        end
        else if (state == read_data)
        begin
            data_low <= !tx_bit;
        end
        else if (state == master_ack)
        begin
            data_low <= !ack_slot && !tx_bit;
        end
        else
        begin
            data_low <= 1'b0;
        end
    end

    assert property (@(posedge sda) disable iff (!rst_n)
        (state == idle || state == ignore) |-> !data_low);

endmodule

// ==== design/i2c_eeprom_top.sv ====
`timescale 1ns/1ps

module i2c_eeprom_top
    import eeprom_pkg::*;
(
    input  logic sda,
    input  logic rst_n,
    input  logic scl,
    input  logic data,
    output logic data_low
);

    logic                  bit_in;
    logic                  scl_rise;
    logic                  scl_fall;
    logic                  start_seen;
    logic                  stop_seen;
    logic                  frame_clear;
    logic                  byte_done;
    logic                  ack_slot;
    logic                  shift_en;
    logic                  load_en;
    logic                  tx_bit;
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [BYTE_WIDTH-1:0] rx_byte;
    logic [BYTE_WIDTH-1:0] rd_byte;

    i2c_line_monitor line_mon0 (
        .sda        (sda),
        .rst_n      (rst_n),
        .scl        (scl),
        .data       (data),
        .bit_in     (bit_in),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen)
    );

    i2c_bit_counter bit_cnt0 (
        .sda         (sda),
        .rst_n       (rst_n),
        .scl_rise    (scl_rise),
        .scl_fall    (scl_fall),
        .frame_clear (frame_clear),
        .bit_index   (),
        .byte_done   (byte_done),
        .ack_slot    (ack_slot)
    );

    // the received byte is also the byte written to the array.
    eeprom_shifter shifter0 (
        .sda       (sda),
        .rst_n     (rst_n),
        .bit_in    (bit_in),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .shift_en  (shift_en),
        .load_en   (load_en),
        .load_byte (rd_byte),
        .rx_byte   (rx_byte),
        .tx_bit    (tx_bit)
    );

    eeprom_array array0 (
        .sda      (sda),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .wr_byte  (rx_byte),
        .rd_byte  (rd_byte)
    );

    i2c_eeprom_ctrl ctrl0 (
        .sda         (sda),
        .rst_n       (rst_n),
        .bit_in      (bit_in),
        .scl_fall    (scl_fall),
        .start_seen  (start_seen),
        .stop_seen   (stop_seen),
        .byte_done   (byte_done),
        .ack_slot    (ack_slot),
        .rx_byte     (rx_byte),
        .tx_bit      (tx_bit),
        .frame_clear (frame_clear),
        .shift_en    (shift_en),
        .load_en     (load_en),
        .mem_we      (mem_we),
        .data_low    (data_low),
        .mem_addr    (mem_addr)
    );

endmodule

// ==== tests/tb_i2c_eeprom.sv ====
`timescale 1ns/1ps

module tb_i2c_eeprom
    import eeprom_pkg::*;
();

    localparam int NUM_OPS = 40;
    // the longest transfer is a four byte random read, seven bytes plus start, restart and stop.
    localparam int XFER_CYCLES = (7 * 9 + 6) * 32;
    localparam int MAX_CYCLES  = (8 + 2 * NUM_OPS) * XFER_CYCLES * 2;

    logic                  sda;
    logic                  rst_n;
    logic                  scl;
    logic                  drive;
    logic                  line;
    logic                  data_low;
    logic                  quiet;
    integer                seed;
    int                    cycles;
    int                    errors;
    logic [BYTE_WIDTH-1:0] model [MEM_DEPTH];
    bit                    valid [MEM_DEPTH];
    logic [ADDR_WIDTH-1:0] ptr_model;
    int                    written [$];

    // the data line is a wired AND of the master drive and the slave pull-down.
    assign line = drive && !data_low;

    i2c_eeprom_top dut0 (
        .sda      (sda),
        .rst_n    (rst_n),
        .scl      (scl),
        .data     (line),
        .data_low (data_low)
    );

    always #4 sda = ~sda;

    always @(posedge sda)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles.", MAX_CYCLES);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    always @(negedge sda)
    begin
        if (quiet)
        begin
            assert (data_low == 1'b0)
            else report_error("data_low is high while the slave should stay off the bus");
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("ERR at %0d ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sda);
        #1;
    endtask

    // one bit slot of 32 cycles, starting and ending with scl low.
    task automatic clock_bit(input logic tx, output logic rx);
        wait_cycles(8);
        drive = tx;
        wait_cycles(8);
        scl = 1'b1;
        wait_cycles(8);
        rx = line;
        wait_cycles(8);
        scl = 1'b0;
    endtask

    task automatic send_start();
        if (!scl)
        begin
            wait_cycles(8);
            drive = 1'b1;
            wait_cycles(8);
            scl = 1'b1;
        end
        wait_cycles(16);
        drive = 1'b0;
        wait_cycles(16);
        scl = 1'b0;
    endtask

    task automatic send_stop();
        wait_cycles(8);
        drive = 1'b0;
        wait_cycles(8);
        scl = 1'b1;
        wait_cycles(16);
        drive = 1'b1;
        wait_cycles(16);
    endtask

    task automatic send_byte(input logic [7:0] b, input logic exp_ack);
        logic r;
        for (int i = 7; i >= 0; i--)
            clock_bit(b[i], r);
        clock_bit(1'b1, r);
        assert (r == !exp_ack)
        else report_error($sformatf("byte %h saw ack bit %b, expected %b", b, r, !exp_ack));
    endtask

    task automatic recv_byte(output logic [7:0] b, input logic ack_it);
        logic r;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, r);
            b[i] = r;
        end
        clock_bit(!ack_it, r);
    endtask

    task automatic byte_write(input logic [ADDR_WIDTH-1:0] addr, input logic [7:0] d);
        send_start();
        send_byte({DEVICE_CODE, addr[ADDR_WIDTH-1:BYTE_WIDTH], 1'b0}, 1'b1);
        send_byte(addr[BYTE_WIDTH-1:0], 1'b1);
        send_byte(d, 1'b1);
        send_stop();
        model[addr] = d;
        valid[addr] = 1'b1;
        ptr_model = addr + 11'd1;
        written.push_back(int'(addr));
    endtask

    // reads n bytes from the pointer, acknowledging all but the last.
    task automatic read_bytes(input int n);
        logic [7:0] got;
        for (int i = 0; i < n; i++)
        begin
            recv_byte(got, i < n - 1);
            assert (got == model[ptr_model])
            else report_error($sformatf("read at %0d returned %h, expected %h",
                                        ptr_model, got, model[ptr_model]));
            ptr_model = ptr_model + 11'd1;
        end
        quiet = 1'b1;
        send_stop();
        quiet = 1'b0;
    endtask

    task automatic random_read(input logic [ADDR_WIDTH-1:0] addr, input int n);
        send_start();
        send_byte({DEVICE_CODE, addr[ADDR_WIDTH-1:BYTE_WIDTH], 1'b0}, 1'b1);
        send_byte(addr[BYTE_WIDTH-1:0], 1'b1);
        send_start();
        send_byte({DEVICE_CODE, addr[ADDR_WIDTH-1:BYTE_WIDTH], 1'b1}, 1'b1);
        ptr_model = addr;
        read_bytes(n);
    endtask

    task automatic current_read(input int n);
        send_start();
        send_byte({DEVICE_CODE, ptr_model[ADDR_WIDTH-1:BYTE_WIDTH], 1'b1}, 1'b1);
        read_bytes(n);
    endtask

    // a full byte write to addr, but with a wrong device code.
    task automatic bad_control(input logic [ADDR_WIDTH-1:0] addr);
        logic [3:0] code;
        code = 4'($random(seed));
        if (code == DEVICE_CODE)
            code = ~code;
        quiet = 1'b1;
        send_start();
        send_byte({code, addr[ADDR_WIDTH-1:BYTE_WIDTH], 1'b0}, 1'b0);
        send_byte(addr[BYTE_WIDTH-1:0], 1'b0);
        send_byte(8'($random(seed)), 1'b0);
        send_stop();
        quiet = 1'b0;
    endtask

    // the stop's own scl rise is one more bit slot, so at most six bits go out first.
    task automatic abort_write(input logic [ADDR_WIDTH-1:0] addr);
        int   nbits;
        logic r;
        nbits = 1 + int'($unsigned($random(seed)) % 6);
        send_start();
        send_byte({DEVICE_CODE, addr[ADDR_WIDTH-1:BYTE_WIDTH], 1'b0}, 1'b1);
        send_byte(addr[BYTE_WIDTH-1:0], 1'b1);
        for (int i = 0; i < nbits; i++)
            clock_bit(1'($random(seed)), r);
        send_stop();
        ptr_model = addr;
    endtask

    function automatic logic [ADDR_WIDTH-1:0] pick_written_addr();
        int idx;
        idx = int'($unsigned($random(seed)) % written.size());
        return ADDR_WIDTH'(written[idx]);
    endfunction

    // number of consecutive written bytes from addr, up to four.
    function automatic int valid_run(input logic [ADDR_WIDTH-1:0] addr);
        int n;
        n = 0;
        while (n < 4 && valid[addr + ADDR_WIDTH'(n)])
            n++;
        return n;
    endfunction

    initial
    begin
        logic [ADDR_WIDTH-1:0] addr;
        int                    op;
        int                    len;
        seed  = 32'h4bdcbe1d;
        sda   = 1'b0;
        rst_n = 1'b0;
        scl   = 1'b1;
        drive = 1'b1;
        quiet = 1'b0;
        wait_cycles(2);
        quiet = 1'b1;
        wait_cycles(14);
        rst_n = 1'b1;
        wait_cycles(100);
        quiet = 1'b0;

        // the pointer wraps from 2047 to 0 after a write and during a read.
        byte_write(11'd2046, 8'($random(seed)));
        byte_write(11'd2047, 8'($random(seed)));
        byte_write(11'd0, 8'($random(seed)));
        byte_write(11'd1, 8'($random(seed)));
        byte_write(11'd2047, 8'($random(seed)));
        current_read(2);
        random_read(11'd2046, 1);
        current_read(3);

        for (int n = 0; n < NUM_OPS; n++)
        begin
            op = int'($unsigned($random(seed)) % 6);
            if (op == 3 && valid_run(ptr_model) == 0)
                op = 0;
            case (op)
                0: byte_write(ptr_model, 8'($random(seed)));
                1:
                begin
                    addr = 11'($random(seed));
                    byte_write(addr, 8'($random(seed)));
                end
                2:
                begin
                    addr = pick_written_addr();
                    len  = 1 + int'($unsigned($random(seed)) % valid_run(addr));
                    random_read(addr, len);
                end
                3: current_read(1 + int'($unsigned($random(seed)) % valid_run(ptr_model)));
                4:
                begin
                    addr = pick_written_addr();
                    bad_control(addr);
                    random_read(addr, 1);
                end
                default:
                begin
                    addr = pick_written_addr();
                    abort_write(addr);
                    random_read(addr, 1);
                end
            endcase
        end

        if (errors == 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
        begin
            $display("Something failed");
            $fatal(1, "errors were found");
        end
    end

endmodule

// ==== build.f ====
design/eeprom_pkg.sv
design/i2c_line_monitor.sv
design/i2c_bit_counter.sv
design/eeprom_shifter.sv
design/eeprom_array.sv
design/i2c_eeprom_ctrl.sv
design/i2c_eeprom_top.sv
tests/tb_i2c_eeprom.sv

// ==== Makefile ====
TOP = tb_i2c_eeprom

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
